// ==== build.f ====
src/board_pkg.sv
src/memory_arbiter.sv
src/memory_eraser.sv
src/rom_signature_check.sv
src/system_ram.sv
src/sigma_delta_dac.sv
src/board_core.sv
verif/board_core_properties.sv
verif/board_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the board_core testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module board_core_tb -Mdir obj_dir -o board_core_sim -f build.f \
	|| { echo "build failed"; exit 1; }
./obj_dir/board_core_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"

// ==== src/board_core.sv ====
`timescale 1ns/1ps

module board_core (
	input  logic                             sys_clock,
	input  logic                             rst_n,
	// host download port
	input  logic                             dl_active,
	input  logic                             dl_wr,
	input  logic [board_pkg::ram_addr_w-1:0] dl_addr,
	input  logic [board_pkg::data_w-1:0]     dl_data,
	input  logic                             boot_done,
	// user controls
	input  logic                             erase_trigger,
	input  logic                             reset_key,
	// cpu RAM pins
	input  logic [board_pkg::ram_addr_w-1:0] cpu_addr,
	input  logic [board_pkg::data_w-1:0]     cpu_wdata,
	// RAM reads every cycle, cpu_rd only kept as a pin
	input  logic                             cpu_rd,
	input  logic                             cpu_wr,
	// audio levels from the sound chip
	input  logic [board_pkg::dac_w-1:0]      channel_l,
	input  logic [board_pkg::dac_w-1:0]      channel_r,
	output logic [board_pkg::data_w-1:0]     cpu_rdata,
	output logic                             cpu_reset,
	output logic                             cpu_wait,
	output logic                             rom_ok_led,
	output logic                             audio_l,
	output logic                             audio_r
);

	// eraser side
	logic                             erasing;
	logic                             era_wr;
	logic [board_pkg::ram_addr_w-1:0] era_addr;
	logic [board_pkg::data_w-1:0]     era_data;

	// checker side
	logic                             checking;
	logic [board_pkg::ram_addr_w-1:0] chk_addr;
	logic                             rom_ok;

	// shared RAM port after the arbiter register
	logic [board_pkg::ram_addr_w-1:0] ram_addr;
	logic [board_pkg::data_w-1:0]     ram_wdata;
	logic                             ram_we;
	logic [board_pkg::data_w-1:0]     ram_q;

	// one read bus for cpu and checker
	assign cpu_rdata  = ram_q;
	assign rom_ok_led = rom_ok;

	memory_arbiter u_arbiter (
		.sys_clock (sys_clock),
		.rst_n     (rst_n),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.boot_done (boot_done),
		.reset_key (reset_key),
		.erasing   (erasing),
		.era_wr    (era_wr),
		.era_addr  (era_addr),
		.era_data  (era_data),
		.checking  (checking),
		.chk_addr  (chk_addr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_wr    (cpu_wr),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.cpu_reset (cpu_reset),
		.cpu_wait  (cpu_wait)
	);

	memory_eraser u_eraser (
		.sys_clock     (sys_clock),
		.rst_n         (rst_n),
		.erase_trigger (erase_trigger),
		.erasing       (erasing),
		.era_wr        (era_wr),
		.era_addr      (era_addr),
		.era_data      (era_data)
	);

	rom_signature_check u_checker (
		.sys_clock (sys_clock),
		.rst_n     (rst_n),
		.boot_done (boot_done),
		.dl_active (dl_active),
		.ram_q     (ram_q),
		.checking  (checking),
		.chk_addr  (chk_addr),
		.rom_ok    (rom_ok)
	);

	system_ram u_ram (
		.sys_clock (sys_clock),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.ram_q     (ram_q)
	);

	// stereo, one modulator per channel
	sigma_delta_dac u_dac_l (
		.sys_clock (sys_clock),
		.rst_n     (rst_n),
		.level     (channel_l),
		.bitstream (audio_l)
	);

	sigma_delta_dac u_dac_r (
		.sys_clock (sys_clock),
		.rst_n     (rst_n),
		.level     (channel_r),
		.bitstream (audio_r)
	);

endmodule

// ==== src/board_pkg.sv ====
package board_pkg;

	// system RAM geometry
	// 4 KB, one byte per address
	localparam int ram_addr_w = 12;
	localparam int ram_depth = 1 << ram_addr_w;

	// top address of the sweep
	localparam logic [ram_addr_w-1:0] ram_last = ram_addr_w'(ram_depth - 1);

	// byte lane
	localparam int data_w = 8;

	// value left behind by an erase
	localparam logic [data_w-1:0] erase_fill = 8'h00;

	// boot ROM signature at addresses 0..3
	// byte for address i sits in bits 8*i+7 : 8*i
	// so address 0 = F3, 1 = C3, 2 = 5A, 3 = 02
	localparam int sig_len = 4;
	localparam int sig_idx_w = $clog2(sig_len);
	localparam logic [sig_len*data_w-1:0] rom_sig = 32'h025a_c3f3;

	// requester address to ram_q
	// one cycle in the arbiter register, one in the RAM read register
	localparam int ram_read_latency = 2;

	// checker busy window and its step counter
	localparam int chk_len = sig_len + ram_read_latency;
	localparam int chk_cnt_w = $clog2(chk_len);

	// audio channel level width
	localparam int dac_w = 8;

endpackage

// ==== src/memory_arbiter.sv ====
`timescale 1ns/1ps

module memory_arbiter (
	input  logic                             sys_clock,
	input  logic                             rst_n,
	input  logic                             dl_active,
	input  logic                             dl_wr,
	input  logic [board_pkg::ram_addr_w-1:0] dl_addr,
	input  logic [board_pkg::data_w-1:0]     dl_data,
	input  logic                             boot_done,
	input  logic                             reset_key,
	input  logic                             erasing,
	input  logic                             era_wr,
	input  logic [board_pkg::ram_addr_w-1:0] era_addr,
	input  logic [board_pkg::data_w-1:0]     era_data,
	input  logic                             checking,
	input  logic [board_pkg::ram_addr_w-1:0] chk_addr,
	input  logic [board_pkg::ram_addr_w-1:0] cpu_addr,
	input  logic [board_pkg::data_w-1:0]     cpu_wdata,
	input  logic                             cpu_wr,
	output logic [board_pkg::ram_addr_w-1:0] ram_addr,
	output logic [board_pkg::data_w-1:0]     ram_wdata,
	output logic                             ram_we,
	output logic                             cpu_reset,
	output logic                             cpu_wait
);

	logic [board_pkg::ram_addr_w-1:0] sel_addr;
	logic [board_pkg::data_w-1:0]     sel_wdata;
	logic                             sel_we;

	// cpu held in reset until boot, on the reset key, and for a whole erase
	assign cpu_reset = ~boot_done | reset_key | erasing;

	// cpu frozen whenever anyone else owns the RAM port
	assign cpu_wait = ~boot_done | dl_active | erasing | checking;

	// fixed priority: download, erase, check, cpu
	// losers are simply ignored, nothing queued
	always_comb begin
		if (dl_active) begin
			sel_addr  = dl_addr;
			sel_wdata = dl_data;
			sel_we    = dl_wr;
		end else if (erasing) begin
			sel_addr  = era_addr;
			sel_wdata = era_data;
			sel_we    = era_wr;
		end else if (checking) begin
			// read only
			sel_addr  = chk_addr;
			sel_wdata = '0;
			sel_we    = 1'b0;
		end else begin
			sel_addr  = cpu_addr;
			sel_wdata = cpu_wdata;
			// still waiting before boot, write is lost
			sel_we    = cpu_wr & ~cpu_wait;
		end
	end

	// address and data into the RAM, one cycle behind the requester
	always_ff @(posedge sys_clock) begin
		ram_addr  <= sel_addr;
		ram_wdata <= sel_wdata;
	end

	// write strobe registered alongside
	always_ff @(posedge sys_clock) begin
		if (!rst_n) begin
			ram_we <= 1'b0;
		end else begin
			ram_we <= sel_we;
		end
	end

endmodule

// ==== src/memory_eraser.sv ====
`timescale 1ns/1ps

module memory_eraser (
	input  logic                             sys_clock,
	input  logic                             rst_n,
	input  logic                             erase_trigger,
	output logic                             erasing,
	output logic                             era_wr,
	output logic [board_pkg::ram_addr_w-1:0] era_addr,
	output logic [board_pkg::data_w-1:0]     era_data
);

	logic sweep_done;

	// last address of the RAM reached this cycle
	assign sweep_done = (era_addr == board_pkg::ram_last);

	// one write per cycle for the whole sweep
	assign era_wr = erasing;

	// constant fill byte
	assign era_data = board_pkg::erase_fill;

	// sweep 0 .. ram_depth-1, erasing high for exactly ram_depth cycles
	always_ff @(posedge sys_clock) begin
		if (!rst_n) begin
			erasing  <= 1'b0;
			era_addr <= '0;
		end else if (erasing) begin
			// triggers ignored mid sweep
			if (sweep_done) begin
				erasing  <= 1'b0;
				era_addr <= '0;
			end else begin
				era_addr <= era_addr + 1'b1;
			end
		end else if (erase_trigger) begin
			// idle and triggered, start at address 0 next cycle
			erasing  <= 1'b1;
			era_addr <= '0;
		end
	end

endmodule

// ==== src/rom_signature_check.sv ====
`timescale 1ns/1ps

module rom_signature_check (
	input  logic                             sys_clock,
	input  logic                             rst_n,
	input  logic                             boot_done,
	input  logic                             dl_active,
	input  logic [board_pkg::data_w-1:0]     ram_q,
	output logic                             checking,
	output logic [board_pkg::ram_addr_w-1:0] chk_addr,
	output logic                             rom_ok
);

	logic                              armed;
	logic                              dl_active_q;
	logic [board_pkg::chk_cnt_w-1:0]   step;
	logic                              mism;
	logic [board_pkg::ram_read_latency-1:0] vld_pipe;
	logic [board_pkg::sig_idx_w-1:0]   idx_pipe [board_pkg::ram_read_latency];
	logic                              dl_rise;
	logic                              start;
	logic                              issue_vld;
	logic                              last_step;
	logic [board_pkg::data_w-1:0]      exp_byte;
	logic                              byte_bad;

	// new download starting
	assign dl_rise = dl_active & ~dl_active_q;

	// once per download, and only after the host is done with the RAM
	assign start = boot_done & armed & ~checking & ~dl_active;

	// addresses 0..sig_len-1 go out on the first sig_len steps
	assign issue_vld = checking & (int'(step) < board_pkg::sig_len);
	assign last_step = (int'(step) == board_pkg::chk_len - 1);

	assign chk_addr = {{(board_pkg::ram_addr_w - board_pkg::sig_idx_w){1'b0}},
		step[board_pkg::sig_idx_w-1:0]};

	// index of the byte now sitting on ram_q
	always_comb begin
		exp_byte = board_pkg::rom_sig[board_pkg::data_w *
			idx_pipe[board_pkg::ram_read_latency-1] +: board_pkg::data_w];
		byte_bad = vld_pipe[board_pkg::ram_read_latency-1] & (ram_q != exp_byte);
	end

	// valid bits follow the read through arbiter and RAM
	always_ff @(posedge sys_clock) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[board_pkg::ram_read_latency-2:0], issue_vld};
		end
	end

	// matching byte index, same delay
	always_ff @(posedge sys_clock) begin
		idx_pipe[0] <= step[board_pkg::sig_idx_w-1:0];
		for (int i = 1; i < board_pkg::ram_read_latency; i++) begin
			idx_pipe[i] <= idx_pipe[i-1];
		end
	end

	always_ff @(posedge sys_clock) begin
		if (!rst_n) begin
			checking    <= 1'b0;
			armed       <= 1'b1;
			rom_ok      <= 1'b0;
			step        <= '0;
			mism        <= 1'b0;
			dl_active_q <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_rise) begin
				// fresh image, forget the old verdict
				armed    <= 1'b1;
				rom_ok   <= 1'b0;
				checking <= 1'b0;
			end else if (start) begin
				checking <= 1'b1;
				armed    <= 1'b0;
				step     <= '0;
				mism     <= 1'b0;
			end else if (checking) begin
				step <= step + 1'b1;
				if (byte_bad) begin
					mism <= 1'b1;
				end
				// last byte compared in this same cycle
				if (last_step) begin
					checking <= 1'b0;
					rom_ok   <= ~(mism | byte_bad);
				end
			end
		end
	end

endmodule

// ==== src/sigma_delta_dac.sv ====
`timescale 1ns/1ps

module sigma_delta_dac (
	input  logic                        sys_clock,
	input  logic                        rst_n,
	input  logic [board_pkg::dac_w-1:0] level,
	output logic                        bitstream
);

	// extra top bit holds the carry of the last add
	logic [board_pkg::dac_w:0] acc;

	// carry out is the pulse density output
	assign bitstream = acc[board_pkg::dac_w];

	// carry dropped before the next add
	// low bits wrap every 2^dac_w cycles, so a window holds exactly level ones
	always_ff @(posedge sys_clock) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[board_pkg::dac_w-1:0]} + {1'b0, level};
		end
	end

endmodule

// ==== src/system_ram.sv ====
`timescale 1ns/1ps

module system_ram (
	input  logic                             sys_clock,
	input  logic [board_pkg::ram_addr_w-1:0] ram_addr,
	input  logic [board_pkg::data_w-1:0]     ram_wdata,
	input  logic                             ram_we,
	output logic [board_pkg::data_w-1:0]     ram_q
);

	// byte wide storage, whole address space
	logic [board_pkg::data_w-1:0] mem [board_pkg::ram_depth];

	// read first: a write cycle returns the previous contents
	always_ff @(posedge sys_clock) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
		end
		ram_q <= mem[ram_addr];
	end

endmodule

// ==== verif/board_core_properties.sv ====
`timescale 1ns/1ps

module board_core_properties (
	input logic sys_clock,
	input logic rst_n,
	input logic dl_active,
	input logic reset_key,
	input logic erasing,
	input logic checking,
	input logic ram_we,
	input logic cpu_wait,
	input logic cpu_reset
);

	// one tally per assertion
	int stray_write_fails = 0;
	int overlap_fails = 0;
	int reset_fails = 0;
	int fail_count;

	assign fail_count = stray_write_fails + overlap_fails + reset_fails;

	// stalled cpu and no download or erase owning the port
	// nothing may reach the RAM write enable one edge later
	no_stray_write: assert property (@(posedge sys_clock) disable iff (!rst_n)
		(cpu_wait && !dl_active && !erasing) |=> !ram_we)
	else begin
		stray_write_fails++;
		$error("RAM write enable raised while the port belonged to no writer");
	end

	// eraser and checker never share the port
	no_erase_check_overlap: assert property (@(posedge sys_clock) disable iff (!rst_n)
		!(erasing && checking))
	else begin
		overlap_fails++;
		$error("erase and signature check running together");
	end

	// a held cpu is also a stalled cpu
	// the reset key alone resets without taking the port
	reset_holds_wait: assert property (@(posedge sys_clock) disable iff (!rst_n)
		cpu_reset |-> (cpu_wait || reset_key))
	else begin
		reset_fails++;
		$error("cpu_reset high without cpu_wait");
	end

endmodule

bind board_core board_core_properties u_props (
	.sys_clock (sys_clock),
	.rst_n     (rst_n),
	.dl_active (dl_active),
	.reset_key (reset_key),
	.erasing   (erasing),
	.checking  (checking),
	.ram_we    (ram_we),
	.cpu_wait  (cpu_wait),
	.cpu_reset (cpu_reset)
);

// ==== verif/board_core_tb.sv ====
`timescale 1ns/1ps

module board_core_tb;

	logic                             sys_clock;
	logic                             rst_n;
	logic                             dl_active;
	logic                             dl_wr;
	logic [board_pkg::ram_addr_w-1:0] dl_addr;
	logic [board_pkg::data_w-1:0]     dl_data;
	logic                             boot_done;
	logic                             erase_trigger;
	logic                             reset_key;
	logic [board_pkg::ram_addr_w-1:0] cpu_addr;
	logic [board_pkg::data_w-1:0]     cpu_wdata;
	logic                             cpu_rd;
	logic                             cpu_wr;
	logic [board_pkg::dac_w-1:0]      channel_l;
	logic [board_pkg::dac_w-1:0]      channel_r;
	logic [board_pkg::data_w-1:0]     cpu_rdata;
	logic                             cpu_reset;
	logic                             cpu_wait;
	logic                             rom_ok_led;
	logic                             audio_l;
	logic                             audio_r;

	// expected RAM contents, follows the arbiter priority rule
	logic [board_pkg::data_w-1:0] model_mem [board_pkg::ram_depth];

	int value_errors = 0;
	int timeouts = 0;

	board_core u_dut (
		.sys_clock     (sys_clock),
		.rst_n         (rst_n),
		.dl_active     (dl_active),
		.dl_wr         (dl_wr),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.boot_done     (boot_done),
		.erase_trigger (erase_trigger),
		.reset_key     (reset_key),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.cpu_rd        (cpu_rd),
		.cpu_wr        (cpu_wr),
		.channel_l     (channel_l),
		.channel_r     (channel_r),
		.cpu_rdata     (cpu_rdata),
		.cpu_reset     (cpu_reset),
		.cpu_wait      (cpu_wait),
		.rom_ok_led    (rom_ok_led),
		.audio_l       (audio_l),
		.audio_r       (audio_r)
	);

	// 10 ns clock
	initial begin
		sys_clock = 1'b0;
		forever #5 sys_clock = ~sys_clock;
	end

	function automatic logic [board_pkg::data_w-1:0] rand_byte();
		logic [31:0] r;
		r = $urandom();
		return r[board_pkg::data_w-1:0];
	endfunction

	function automatic logic [board_pkg::ram_addr_w-1:0] rand_addr();
		logic [31:0] r;
		r = $urandom();
		return r[board_pkg::ram_addr_w-1:0];
	endfunction

	// boot signature as the loader expects it, address 0 first
	function automatic logic [board_pkg::data_w-1:0] sig_byte(input int idx);
		case (idx)
			0: return 8'hf3;
			1: return 8'hc3;
			2: return 8'h5a;
			default: return 8'h02;
		endcase
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			value_errors++;
			$display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// polls cpu_wait on falling edges, bounded by limit
	task automatic await_cpu_wait(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge sys_clock);
		while (cpu_wait !== level && n < limit) begin
			@(negedge sys_clock);
			n++;
		end
		if (cpu_wait !== level) begin
			timeouts++;
			$display("timeout: cpu_wait never went to %0d while %s", level, what);
		end
	endtask

	// one cpu write strobe, address and data on the same edge
	task automatic store_byte(input logic [board_pkg::ram_addr_w-1:0] addr,
		input logic [board_pkg::data_w-1:0] data);
		@(posedge sys_clock);
		cpu_addr  <= addr;
		cpu_wdata <= data;
		cpu_wr    <= 1'b1;
		@(posedge sys_clock);
		cpu_wr <= 1'b0;
	endtask

	// read data sits on cpu_rdata two edges after the address
	task automatic fetch_byte(input logic [board_pkg::ram_addr_w-1:0] addr,
		output logic [board_pkg::data_w-1:0] data);
		@(posedge sys_clock);
		cpu_addr <= addr;
		cpu_rd   <= 1'b1;
		@(posedge sys_clock);
		cpu_rd <= 1'b0;
		repeat (board_pkg::ram_read_latency - 1) @(posedge sys_clock);
		@(negedge sys_clock);
		data = cpu_rdata;
	endtask

	task automatic open_download();
		@(posedge sys_clock);
		dl_active <= 1'b1;
		repeat (2) @(posedge sys_clock);
	endtask

	// full image, signature in front, byte 1 spoiled on request
	task automatic download_image(input logic good_sig);
		int i;
		logic [board_pkg::ram_addr_w-1:0] a;
		logic [board_pkg::data_w-1:0] d;
		for (i = 0; i < board_pkg::ram_depth; i++) begin
			a = i[board_pkg::ram_addr_w-1:0];
			if (i < board_pkg::sig_len) begin
				d = sig_byte(i);
			end else begin
				d = rand_byte();
			end
			if (!good_sig && i == 1) begin
				d = ~d;
			end
			@(posedge sys_clock);
			dl_addr <= a;
			dl_data <= d;
			dl_wr   <= 1'b1;
			model_mem[a] = d;
		end
		@(posedge sys_clock);
		dl_wr <= 1'b0;
	endtask

	task automatic close_download();
		@(posedge sys_clock);
		dl_active <= 1'b0;
	endtask

	// length of a cpu_reset pulse in cycles
	task automatic measure_reset_pulse(output int cycles);
		int n;
		n = 0;
		cycles = 0;
		@(negedge sys_clock);
		while (cpu_reset !== 1'b1 && n < 8) begin
			@(negedge sys_clock);
			n++;
		end
		if (cpu_reset !== 1'b1) begin
			timeouts++;
			$display("timeout: cpu_reset never rose after the erase trigger");
		end else begin
			while (cpu_reset === 1'b1 && cycles < board_pkg::ram_depth + 8) begin
				cycles++;
				@(negedge sys_clock);
			end
			if (cpu_reset === 1'b1) begin
				timeouts++;
				$display("timeout: cpu_reset stuck high after the erase");
			end
		end
	endtask

	initial begin
		logic [board_pkg::ram_addr_w-1:0] a;
		logic [board_pkg::data_w-1:0] d;
		logic [board_pkg::data_w-1:0] got;
		logic [board_pkg::dac_w-1:0] lvl_l;
		logic [board_pkg::dac_w-1:0] lvl_r;
		int i;
		int cycles;
		int ones_l;
		int ones_r;
		int prop_fails;
		void'($urandom(32'h40a0_3ab7));
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		boot_done = 1'b0;
		erase_trigger = 1'b0;
		reset_key = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		channel_l = '0;
		channel_r = '0;
		repeat (16) @(posedge sys_clock);
		rst_n <= 1'b1;

		// before boot, cpu held and its writes dropped
		store_byte(rand_addr(), rand_byte());
		for (i = 0; i < 4; i++) begin
			@(negedge sys_clock);
			check_value(32'(cpu_reset), 32'd1, "cpu_reset before boot");
			check_value(32'(cpu_wait), 32'd1, "cpu_wait before boot");
			check_value(32'(rom_ok_led), 32'd0, "rom_ok_led before boot");
			check_value(32'(audio_l | audio_r), 32'd0, "audio with silent channels");
		end

		// good image, then boot
		open_download();
		@(negedge sys_clock);
		check_value(32'(rom_ok_led), 32'd0, "rom_ok_led at first download");
		download_image(1'b1);
		close_download();
		@(posedge sys_clock);
		boot_done <= 1'b1;
		// short gap before the check takes the port
		await_cpu_wait(1'b1, 8, "waiting for the first check");
		await_cpu_wait(1'b0, 32, "the first check ran");
		check_value(32'(rom_ok_led), 32'd1, "rom_ok_led after good image");
		for (i = 0; i < 16; i++) begin
			a = rand_addr();
			fetch_byte(a, got);
			check_value(32'(got), 32'(model_mem[a]), "cpu read after download");
		end

		// cpu writes land once the port is free
		for (i = 0; i < 8; i++) begin
			a = rand_addr();
			d = rand_byte();
			store_byte(a, d);
			model_mem[a] = d;
			fetch_byte(a, got);
			check_value(32'(got), 32'(d), "cpu write read back");
		end

		// bad image, plus a cpu write that loses to the download
		open_download();
		@(negedge sys_clock);
		check_value(32'(rom_ok_led), 32'd0, "rom_ok_led at second download");
		download_image(1'b0);
		a = rand_addr();
		store_byte(a, ~model_mem[a]);
		close_download();
		await_cpu_wait(1'b1, 8, "waiting for the second check");
		await_cpu_wait(1'b0, 32, "the second check ran");
		check_value(32'(rom_ok_led), 32'd0, "rom_ok_led after bad image");
		fetch_byte(a, got);
		check_value(32'(got), 32'(model_mem[a]), "cpu write during download dropped");

		// erase sweep
		@(posedge sys_clock);
		erase_trigger <= 1'b1;
		@(posedge sys_clock);
		erase_trigger <= 1'b0;
		measure_reset_pulse(cycles);
		check_value(32'(cycles), 32'(board_pkg::ram_depth), "cpu_reset length during erase");
		for (i = 0; i < board_pkg::ram_depth; i++) begin
			model_mem[i[board_pkg::ram_addr_w-1:0]] = board_pkg::erase_fill;
		end
		for (i = 0; i < 20; i++) begin
			// both ends of the RAM, then random spots
			if (i < board_pkg::sig_len) begin
				a = i[board_pkg::ram_addr_w-1:0];
			end else if (i == board_pkg::sig_len) begin
				a = '1;
			end else begin
				a = rand_addr();
			end
			fetch_byte(a, got);
			check_value(32'(got), 32'(model_mem[a]), "read after erase");
		end

		// audio, one 256 cycle window after settling
		lvl_l = rand_byte();
		lvl_r = rand_byte();
		@(posedge sys_clock);
		channel_l <= lvl_l;
		channel_r <= lvl_r;
		repeat (256) @(posedge sys_clock);
		ones_l = 0;
		ones_r = 0;
		for (i = 0; i < 256; i++) begin
			@(negedge sys_clock);
			ones_l += int'(audio_l);
			ones_r += int'(audio_r);
		end
		check_value(32'(ones_l), 32'(lvl_l), "ones on audio_l");
		check_value(32'(ones_r), 32'(lvl_r), "ones on audio_r");

		prop_fails = u_dut.u_props.fail_count;
		$display("closing: %0d value errors, %0d timeouts, %0d property failures",
			value_errors, timeouts, prop_fails);
		if (value_errors + timeouts + prop_fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
